// ==== hw/cmd_consts.svh ====
// command processor constants for command framing, opcodes, read-back codes and SPI timing
`ifndef CMD_CONSTS_SVH
`define CMD_CONSTS_SVH

// command framing
`define CMD_BYTES       8

`define OP_ARM          8'd1    // arm trigger and read acquisition state
`define OP_READ         8'd2    // read-back selector
`define OP_SPI          8'd3    // SPI transaction
`define OP_TRIG         8'd8    // trigger thresholds
`define OP_DOWNSAMPLE   8'd9    // downsample and high-res
`define OP_BOARDOUT     8'd10   // single boardout bit
`define OP_HANG         8'd13   // never answers

// sub-codes of OP_READ, found in byte 1
`define RD_VERSION      8'd0
`define RD_BOARDIN      8'd1
`define RD_ROLLING      8'd8
`define RD_WATCHDOG     8'd22

`define FW_VERSION      32'd32

`define SPI_CS_SETUP    10      // cycles from cs low to first byte
`define SPI_CS_HOLD     35      // cycles from last byte to cs high

`endif

// ==== hw/cmd_pkg.sv ====
// shared types of the command path, i.e. command, response, SPI job and trigger settings
`include "cmd_consts.svh"

package cmd_pkg;

   // byte 0 is the opcode, it arrives first
   typedef logic [`CMD_BYTES-1:0][7:0] cmd_t;

   // one response beat on the word stream
   typedef logic [31:0] resp_t;

   typedef struct packed {
      logic [2:0]      chip;   // chip select index
      logic [7:0]      count;  // bytes to send, clamped by the sequencer
      logic [3:0][7:0] tx;     // tx[0] goes out first
      logic [1:0]      rsvd;   // always zero
   } spi_job_t;

   // settings that go to the triggerer
   typedef struct packed {
      logic signed [23:0] lower_thresh;  // [23:12] runt level, [11:0] main level
      logic signed [23:0] upper_thresh;  // same split as lower
      logic [7:0]         trig_type;
      logic [15:0]        length;        // samples to take
      logic [9:0]         pre_offset;
      logic [7:0]         tot;           // time over threshold
      logic               trig_chan;
      logic               live;
      logic               rolling;
      logic [4:0]         downsample;
      logic               high_res;
      logic [7:0]         merging;
   } trig_cfg_t;

endpackage

// ==== hw/cmd_receiver.sv ====
// command receiver, packs eight stream bytes into a command and hands it on by req/ack
`include "cmd_consts.svh"

module cmd_receiver (
   input  logic          clk50,
   input  logic          pllreset2,
   input  logic          i_rx_valid,
   input  logic [7:0]    i_rx_data,
   output logic          o_rx_ready,
   output logic          o_cmd_req,
   input  logic          i_cmd_ack,
   output cmd_pkg::cmd_t o_cmd
);

   localparam int CNT_W = $clog2(`CMD_BYTES);

   logic [CNT_W-1:0] byte_cnt;
   logic             full;   // a complete command is held
   logic             take;

   assign o_rx_ready = !full;  // back-pressure while a command is out
   assign take = i_rx_valid && o_rx_ready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt  <= '0;
         full      <= 1'b0;
         o_cmd_req <= 1'b0;
      end else begin
         if (take) begin
            if (byte_cnt == CNT_W'(`CMD_BYTES - 1)) begin
               byte_cnt  <= '0;
               full      <= 1'b1;
               o_cmd_req <= 1'b1;  // last byte in
            end else begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end
         if (o_cmd_req && i_cmd_ack) o_cmd_req <= 1'b0;
         if (full && !o_cmd_req && !i_cmd_ack) full <= 1'b0;  // handshake closed
      end
   end

   always_ff @(posedge clk50) begin
      if (take) o_cmd[byte_cnt] <= i_rx_data;  // arrival order
   end

   a_cmd_stable : assert property (@(posedge clk50) disable iff (pllreset2)
      o_cmd_req |=> (!o_cmd_req || $stable(o_cmd)));

endmodule

// ==== hw/resp_sender.sv ====
// response sender, drives one word onto the outbound stream per req/ack cycle
module resp_sender (
   input  logic           clk50,
   input  logic           pllreset2,
   input  logic           i_resp_req,
   output logic           o_resp_ack,
   input  cmd_pkg::resp_t i_resp,
   output logic           o_tx_valid,
   output cmd_pkg::resp_t o_tx_data,
   input  logic           i_tx_ready
);

   logic launch;

   // new word only once the previous cycle has fully closed
   assign launch = i_resp_req && !o_tx_valid && !o_resp_ack;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_tx_valid <= 1'b0;
         o_resp_ack <= 1'b0;
      end else begin
         if (launch) begin
            o_tx_valid <= 1'b1;
         end else if (o_tx_valid && i_tx_ready) begin
            o_tx_valid <= 1'b0;  // word taken
            o_resp_ack <= 1'b1;
         end
         if (o_resp_ack && !i_resp_req) o_resp_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk50) begin
      if (launch) o_tx_data <= i_resp;
   end

   a_tx_hold : assert property (@(posedge clk50) disable iff (pllreset2)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data));

endmodule

// ==== hw/spi_sequencer.sv ====
// SPI sequencer, frames a 2 to 4 byte transfer with chip select around an external SPI master
`include "cmd_consts.svh"

module spi_sequencer (
   input  logic              clk50,
   input  logic              pllreset2,
   input  logic              i_spi_req,
   output logic              o_spi_ack,
   input  cmd_pkg::spi_job_t i_job,
   output logic [15:0]       o_rx_word,
   output logic [7:0]        o_spi_tx,
   output logic              o_spi_tx_dv,
   input  logic              i_spi_tx_ready,
   input  logic [7:0]        i_spi_rx,
   input  logic              i_spi_rx_dv,
   output logic [7:0]        o_spi_cs,
   output logic [2:0]        o_spi_miso_sel
);

   typedef enum logic [2:0] {
      S_IDLE, S_SETUP, S_SEND, S_WAIT_RX, S_HOLD, S_ACK
   } state_t;

   state_t            state;
   cmd_pkg::spi_job_t job_q;
   logic [5:0]        wait_cnt;
   logic [1:0]        byte_idx;
   logic [1:0]        last_idx;
   logic [1:0]        last_idx_d;
   logic              start;

   assign start = (state == S_IDLE) && i_spi_req;

   // count outside 2..4 gets clamped
   always_comb begin
      if (i_job.count < 8'd2) last_idx_d = 2'd1;
      else if (i_job.count > 8'd4) last_idx_d = 2'd3;
      else last_idx_d = 2'(i_job.count - 8'd1);
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state          <= S_IDLE;
         o_spi_ack      <= 1'b0;
         o_spi_tx_dv    <= 1'b0;
         o_spi_cs       <= 8'hff;
         o_spi_miso_sel <= 3'd0;
         wait_cnt       <= '0;
         byte_idx       <= '0;
         last_idx       <= '0;
      end else begin
         case (state)
            S_IDLE: if (start) begin
               o_spi_cs       <= ~(8'd1 << i_job.chip);
               o_spi_miso_sel <= i_job.chip;
               byte_idx       <= '0;
               last_idx       <= last_idx_d;
               state          <= S_SETUP;
            end
            S_SETUP: begin
               wait_cnt <= wait_cnt + 6'd1;
               if (wait_cnt == 6'(`SPI_CS_SETUP - 1)) begin
                  wait_cnt <= '0;
                  state    <= S_SEND;
               end
            end
            S_SEND: if (i_spi_tx_ready) begin
               o_spi_tx_dv <= 1'b1;  // single-cycle strobe
               state       <= S_WAIT_RX;
            end
            S_WAIT_RX: begin
               o_spi_tx_dv <= 1'b0;
               if (i_spi_rx_dv) begin
                  byte_idx <= byte_idx + 2'd1;
                  state    <= (byte_idx == last_idx) ? S_HOLD : S_SEND;
               end
            end
            S_HOLD: begin
               wait_cnt <= wait_cnt + 6'd1;
               if (wait_cnt == 6'(`SPI_CS_HOLD - 1)) begin
                  wait_cnt  <= '0;
                  o_spi_cs  <= 8'hff;
                  o_spi_ack <= 1'b1;
                  state     <= S_ACK;
               end
            end
            S_ACK: if (!i_spi_req) begin
               o_spi_ack <= 1'b0;
               state     <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (start) job_q <= i_job;
      if (state == S_SEND) o_spi_tx <= job_q.tx[byte_idx];
      if (state == S_WAIT_RX && i_spi_rx_dv) o_rx_word <= {o_rx_word[7:0], i_spi_rx};
   end

   a_one_cs : assert property (@(posedge clk50) disable iff (pllreset2)
      o_spi_tx_dv |-> $onehot(~o_spi_cs));

endmodule

// ==== hw/cmd_dispatcher.sv ====
// command dispatcher, decodes opcodes, keeps the settings and watchdog, sequences responses
`include "cmd_consts.svh"

module cmd_dispatcher #(
   parameter int unsigned WATCHDOG_LIMIT = 500000000
) (
   input  logic               clk50,
   input  logic               pllreset2,
   input  logic               i_cmd_req,
   output logic               o_cmd_ack,
   input  cmd_pkg::cmd_t      i_cmd,
   output logic               o_resp_req,
   input  logic               i_resp_ack,
   output cmd_pkg::resp_t     o_resp,
   output logic               o_spi_req,
   input  logic               i_spi_ack,
   output cmd_pkg::spi_job_t  o_spi_job,
   input  logic [15:0]        i_spi_rx_word,
   input  logic [7:0]         i_acqstate,
   input  logic [7:0]         i_boardin,
   output cmd_pkg::trig_cfg_t o_trig_cfg,
   output logic [7:0]         o_boardout
);

   typedef enum logic [2:0] {
      D_IDLE, D_RESP, D_RESP_END, D_SPI, D_SPI_END, D_CMD_ACK, D_HANG
   } state_t;

   state_t      state;
   logic [7:0]  acq_sync;
   logic [7:0]  boardin_sync;
   logic [31:0] wd_timer;
   logic [31:0] wd_count;
   logic        start;
   logic        busy;
   logic        wd_fire;
   logic [11:0] lo_level;
   logic [11:0] hi_level;

   // level in adc counts, centred and scaled to 12 bits
   function automatic logic [11:0] thr12(input logic [11:0] level);
      thr12 = ((level - 12'd128) << 4) + 12'd8;
   endfunction

   // stale acks from an aborted command must clear first
   assign start    = i_cmd_req && !o_cmd_ack && !i_resp_ack && !i_spi_ack;
   assign busy     = (state != D_IDLE) && (state != D_CMD_ACK);
   assign wd_fire  = busy && (wd_timer == 32'(WATCHDOG_LIMIT - 1));
   assign lo_level = 12'(i_cmd[1]) - 12'(i_cmd[2]);
   assign hi_level = 12'(i_cmd[1]) + 12'(i_cmd[2]);

   always_ff @(posedge clk50) begin
      acq_sync     <= i_acqstate;
      boardin_sync <= i_boardin;
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state      <= D_IDLE;
         o_cmd_ack  <= 1'b0;
         o_resp_req <= 1'b0;
         o_spi_req  <= 1'b0;
         o_trig_cfg <= '0;
         o_boardout <= '0;
         wd_timer   <= '0;
         wd_count   <= '0;
      end else begin
         wd_timer <= busy ? wd_timer + 32'd1 : '0;
         case (state)
            D_IDLE: if (start) begin
               o_resp_req <= 1'b1;  // most commands answer at once
               state      <= D_RESP;
               case (i_cmd[0])
                  `OP_ARM: begin
                     o_trig_cfg.trig_type <= i_cmd[1];
                     o_trig_cfg.length    <= {i_cmd[5], i_cmd[4]};
                     o_trig_cfg.live      <= (acq_sync == 8'd0);
                     o_resp               <= {24'd0, acq_sync};
                  end
                  `OP_READ: case (i_cmd[1])
                     `RD_VERSION:  o_resp <= `FW_VERSION;
                     `RD_BOARDIN:  o_resp <= {24'd0, boardin_sync};
                     `RD_ROLLING: begin
                        o_trig_cfg.rolling <= i_cmd[2][0];
                        o_resp             <= {31'd0, o_trig_cfg.rolling};  // old value
                     end
                     `RD_WATCHDOG: o_resp <= wd_count;
                     default:      o_resp <= '0;
                  endcase
                  `OP_TRIG: begin
                     o_trig_cfg.lower_thresh[11:0] <= thr12(lo_level);
                     o_trig_cfg.upper_thresh[11:0] <= thr12(hi_level);
                     if (i_cmd[7][7]) begin  // runt rejection off
                        o_trig_cfg.lower_thresh[23:12] <= 12'h800;
                        o_trig_cfg.upper_thresh[23:12] <= 12'h7ff;
                     end else begin
                        o_trig_cfg.lower_thresh[23:12] <= thr12(lo_level - 12'(i_cmd[7]));
                        o_trig_cfg.upper_thresh[23:12] <= thr12(hi_level + 12'(i_cmd[7]));
                     end
                     o_trig_cfg.pre_offset <= {i_cmd[3][1:0], i_cmd[4]};
                     o_trig_cfg.tot        <= i_cmd[5];
                     o_trig_cfg.trig_chan  <= i_cmd[6][0];
                     o_resp                <= 32'd8;
                  end
                  `OP_DOWNSAMPLE: begin
                     o_trig_cfg.downsample <= i_cmd[1][4:0];
                     o_trig_cfg.high_res   <= i_cmd[2][0];
                     o_trig_cfg.merging    <= i_cmd[3];
                     o_resp                <= 32'd9;
                  end
                  `OP_BOARDOUT: begin
                     o_boardout[i_cmd[1][2:0]] <= i_cmd[2][0];
                     o_resp                    <= {24'd0, o_boardout};
                  end
                  `OP_SPI: begin
                     o_spi_job.chip  <= i_cmd[1][2:0];
                     o_spi_job.count <= i_cmd[7];
                     o_spi_job.tx    <= i_cmd[5:2];  // b2 goes first
                     o_spi_job.rsvd  <= 2'b00;
                     o_resp_req      <= 1'b0;
                     o_spi_req       <= 1'b1;
                     state           <= D_SPI;
                  end
                  `OP_HANG: begin
                     o_resp_req <= 1'b0;
                     state      <= D_HANG;
                  end
                  default: begin  // unknown, ack silently
                     o_resp_req <= 1'b0;
                     o_cmd_ack  <= 1'b1;
                     state      <= D_CMD_ACK;
                  end
               endcase
            end
            D_SPI: if (i_spi_ack) begin
               o_spi_req <= 1'b0;
               o_resp    <= {16'd0, i_spi_rx_word};
               state     <= D_SPI_END;
            end
            D_SPI_END: if (!i_spi_ack) begin
               o_resp_req <= 1'b1;
               state      <= D_RESP;
            end
            D_RESP: if (i_resp_ack) begin
               o_resp_req <= 1'b0;
               state      <= D_RESP_END;
            end
            D_RESP_END: if (!i_resp_ack) begin
               o_cmd_ack <= 1'b1;
               state     <= D_CMD_ACK;
            end
            D_CMD_ACK: if (!i_cmd_req) begin
               o_cmd_ack <= 1'b0;
               state     <= D_IDLE;
            end
            D_HANG: state <= D_HANG;  // only the watchdog gets out
            default: state <= D_IDLE;
         endcase
         if (wd_fire) begin  // abort whatever is running
            o_resp_req <= 1'b0;
            o_spi_req  <= 1'b0;
            o_cmd_ack  <= 1'b1;
            wd_count   <= wd_count + 32'd1;
            state      <= D_CMD_ACK;
         end
      end
   end

   a_one_req : assert property (@(posedge clk50) disable iff (pllreset2)
      !(o_resp_req && o_spi_req));

endmodule

// ==== hw/command_processor_top.sv ====
// command processor top, joins receiver, dispatcher, response sender and SPI sequencer
module command_processor_top #(
   parameter int unsigned WATCHDOG_LIMIT = 500000000
) (
   input  logic               clk50,
   input  logic               pllreset2,
   input  logic               i_rx_valid,
   input  logic [7:0]         i_rx_data,
   output logic               o_rx_ready,
   output logic               o_tx_valid,
   output cmd_pkg::resp_t     o_tx_data,
   input  logic               i_tx_ready,
   output logic [7:0]         o_spi_tx,
   output logic               o_spi_tx_dv,
   input  logic               i_spi_tx_ready,
   input  logic [7:0]         i_spi_rx,
   input  logic               i_spi_rx_dv,
   output logic [7:0]         o_spi_cs,
   output logic [2:0]         o_spi_miso_sel,
   input  logic [7:0]         i_acqstate,
   input  logic [7:0]         i_boardin,
   output cmd_pkg::trig_cfg_t o_trig_cfg,
   output logic [7:0]         o_boardout
);

   cmd_pkg::cmd_t     cmd;
   cmd_pkg::resp_t    resp;
   cmd_pkg::spi_job_t spi_job;
   logic              cmd_req;
   logic              cmd_ack;
   logic              resp_req;
   logic              resp_ack;
   logic              spi_req;
   logic              spi_ack;
   logic [15:0]       spi_rx_word;

   cmd_receiver u_rx (
      .clk50, .pllreset2, .i_rx_valid, .i_rx_data, .o_rx_ready,
      .o_cmd_req(cmd_req), .i_cmd_ack(cmd_ack), .o_cmd(cmd)
   );

   cmd_dispatcher #(.WATCHDOG_LIMIT(WATCHDOG_LIMIT)) u_disp (
      .clk50, .pllreset2,
      .i_cmd_req(cmd_req), .o_cmd_ack(cmd_ack), .i_cmd(cmd),
      .o_resp_req(resp_req), .i_resp_ack(resp_ack), .o_resp(resp),
      .o_spi_req(spi_req), .i_spi_ack(spi_ack), .o_spi_job(spi_job),
      .i_spi_rx_word(spi_rx_word),
      .i_acqstate, .i_boardin, .o_trig_cfg, .o_boardout
   );

   resp_sender u_tx (
      .clk50, .pllreset2, .i_resp_req(resp_req), .o_resp_ack(resp_ack), .i_resp(resp),
      .o_tx_valid, .o_tx_data, .i_tx_ready
   );

   spi_sequencer u_spi (
      .clk50, .pllreset2, .i_spi_req(spi_req), .o_spi_ack(spi_ack), .i_job(spi_job),
      .o_rx_word(spi_rx_word), .o_spi_tx, .o_spi_tx_dv, .i_spi_tx_ready,
      .i_spi_rx, .i_spi_rx_dv, .o_spi_cs, .o_spi_miso_sel
   );

endmodule

// ==== dv/tb_command_processor.sv ====
// testbench for the command processor, sends commands and checks responses and settings
`include "cmd_consts.svh"

module tb_command_processor;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WD_LIMIT = 2000;
   localparam int TIMEOUT_CYCLES = 20 * (2 * WD_LIMIT + 200);  // 20 commands worst case

   logic               clk50 = 1'b0;
   logic               pllreset2;
   logic               i_rx_valid;
   logic [7:0]         i_rx_data;
   logic               o_rx_ready;
   logic               o_tx_valid;
   cmd_pkg::resp_t     o_tx_data;
   logic               i_tx_ready = 1'b0;
   logic [7:0]         o_spi_tx;
   logic               o_spi_tx_dv;
   logic               i_spi_tx_ready = 1'b1;
   logic [7:0]         i_spi_rx = 8'd0;
   logic               i_spi_rx_dv = 1'b0;
   logic [7:0]         o_spi_cs;
   logic [2:0]         o_spi_miso_sel;
   logic [7:0]         i_acqstate;
   logic [7:0]         i_boardin;
   cmd_pkg::trig_cfg_t o_trig_cfg;
   logic [7:0]         o_boardout;

   logic [31:0] exp_q[$];       // expected response words in order
   string       name_q[$];
   logic [31:0] exp_head = '0;
   string       exp_name = "";
   logic        exp_valid = 1'b0;
   logic        tx_fire_q = 1'b0;
   int          words_seen = 0;
   int          words_due = 0;
   logic [31:0] rng = 32'h9e2a_5a7c;
   int          cycles = 0;
   logic [7:0]  bo_model = 8'd0;  // boardout as the host believes it
   logic [2:0]  spi_chip = 3'd0;
   int          spi_len = 0;
   int          spi_base = 0;
   int          spi_dv_total = 0;
   logic [7:0]  spi_bytes [4] = '{default: 8'd0};
   logic [7:0]  rx_byte = 8'd0;
   logic [2:0]  rx_delay = 3'd0;

   command_processor_top #(.WATCHDOG_LIMIT(WD_LIMIT)) dut0 (.*);

   always #10 clk50 = ~clk50;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // threshold code for a level relative to mid-scale
   function automatic logic [11:0] thresh_code(input int level);
      return 12'(level * 16 + 8);
   endfunction

   function automatic cmd_pkg::cmd_t cmd8(input logic [7:0] b0, b1, b2, b3, b4, b5, b6, b7);
      return {b7, b6, b5, b4, b3, b2, b1, b0};  // byte 0 in the low lane
   endfunction

   task automatic flag_mismatch(input string name, input logic [31:0] want, input logic [31:0] got);
      $display("[ERROR] %s: expected %08h, actual %08h", name, want, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check failed");
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_field(input string name, input logic [31:0] want, input logic [31:0] got);
      chk_field : assert (got === want) else flag_mismatch(name, want, got);
   endtask

   task automatic send_cmd(input cmd_pkg::cmd_t c);
      for (int i = 0; i < `CMD_BYTES; i++) begin
         i_rx_valid <= 1'b1;
         i_rx_data  <= c[i];
         @(posedge clk50);
         while (!o_rx_ready) @(posedge clk50);  // host held off
      end
      i_rx_valid <= 1'b0;
   endtask

   task automatic run_cmd(input string name, input logic [31:0] want, input cmd_pkg::cmd_t c);
      exp_q.push_back(want);
      name_q.push_back(name);
      words_due++;
      send_cmd(c);
      while (words_seen < words_due) @(posedge clk50);
   endtask

   task automatic run_trig(input logic [7:0] b1, b2, b3, b4, b5, b6, b7);
      int          lo;
      int          hi;
      logic [23:0] want_lo;
      logic [23:0] want_hi;
      lo = int'(b1) - int'(b2) - 128;
      hi = int'(b1) + int'(b2) - 128;
      want_lo[11:0]  = thresh_code(lo);
      want_hi[11:0]  = thresh_code(hi);
      want_lo[23:12] = (b7 >= 8'd128) ? 12'h800 : thresh_code(lo - int'(b7));  // runt level
      want_hi[23:12] = (b7 >= 8'd128) ? 12'h7ff : thresh_code(hi + int'(b7));
      run_cmd("trig echo", 32'd8, cmd8(`OP_TRIG, b1, b2, b3, b4, b5, b6, b7));
      check_field("trig lower", want_lo, {8'd0, o_trig_cfg.lower_thresh});
      check_field("trig upper", want_hi, {8'd0, o_trig_cfg.upper_thresh});
      check_field("trig pre-offset", int'(b3[1:0]) * 256 + int'(b4), o_trig_cfg.pre_offset);
      check_field("trig tot", b5, o_trig_cfg.tot);
      check_field("trig channel", b6[0], o_trig_cfg.trig_chan);
   endtask

   task automatic run_arm(input logic [7:0] acq, input logic [7:0] b1, b4, b5);
      i_acqstate <= acq;
      run_cmd("arm acqstate", {24'd0, acq}, cmd8(`OP_ARM, b1, '0, '0, b4, b5, '0, '0));
      check_field("arm trig type", b1, o_trig_cfg.trig_type);
      check_field("arm length", {b5, b4}, o_trig_cfg.length);
      check_field("arm live", acq == 8'd0, o_trig_cfg.live);
   endtask

   task automatic run_boardout(input logic [2:0] idx, input logic val);
      run_cmd("boardout previous", {24'd0, bo_model}, cmd8(`OP_BOARDOUT, {5'd0, idx}, {7'd0, val},
         '0, '0, '0, '0, '0));
      bo_model[idx] = val;
      check_field("boardout", bo_model, o_boardout);
   endtask

   task automatic run_spi(input logic [2:0] chip, input int n, input logic [7:0] t0, t1, t2, t3);
      logic [31:0] want;
      spi_chip  = chip;
      spi_len   = n;
      spi_base  = spi_dv_total;
      spi_bytes = '{t0, t1, t2, t3};
      want = {16'd0, spi_bytes[n-2] ^ 8'h5a, spi_bytes[n-1] ^ 8'h5a};  // last two echoes
      run_cmd("spi rx word", want, cmd8(`OP_SPI, {5'd0, chip}, t0, t1, t2, t3, '0, 8'(n)));
      check_field("spi byte count", n, spi_dv_total - spi_base);
   endtask

   // random back-pressure on the outbound stream
   always @(posedge clk50) begin
      rng = lcg_next(rng);
      i_tx_ready <= rng[23] | rng[17];
   end

   // spi master model, echoes each byte xor 5a a few cycles later
   always @(posedge clk50) begin
      i_spi_rx_dv <= 1'b0;
      if (o_spi_tx_dv) begin
         spi_dv_total   <= spi_dv_total + 1;
         rx_byte        <= o_spi_tx ^ 8'h5a;
         rx_delay       <= 3'd3;
         i_spi_tx_ready <= 1'b0;
      end else if (rx_delay != 3'd0) begin
         rx_delay <= rx_delay - 3'd1;
         if (rx_delay == 3'd1) begin
            i_spi_rx       <= rx_byte;
            i_spi_rx_dv    <= 1'b1;
            i_spi_tx_ready <= 1'b1;
         end
      end
   end

   // expected head moves at negedge so it is steady at each rising edge
   always @(posedge clk50) tx_fire_q <= o_tx_valid && i_tx_ready && !pllreset2;

   always @(negedge clk50) begin
      if (tx_fire_q) begin
         void'(exp_q.pop_front());
         void'(name_q.pop_front());
         words_seen++;
      end
      exp_valid = exp_q.size() != 0;
      if (exp_valid) begin
         exp_head = exp_q[0];
         exp_name = name_q[0];
      end
   end

   always @(posedge clk50) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) abort_run("run did not finish within the cycle limit");
   end

   a_resp_expected : assert property (@(posedge clk50) disable iff (pllreset2)
      o_tx_valid && i_tx_ready |-> exp_valid)
      else abort_run("a response word arrived that no command should produce");

   a_resp_value : assert property (@(posedge clk50) disable iff (pllreset2)
      o_tx_valid && i_tx_ready && exp_valid |-> o_tx_data == exp_head)
      else flag_mismatch(exp_name, exp_head, o_tx_data);

   a_tx_hold : assert property (@(posedge clk50) disable iff (pllreset2)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data))
      else abort_run("outbound word changed or dropped before it was accepted");

   a_spi_cs : assert property (@(posedge clk50) disable iff (pllreset2)
      o_spi_tx_dv |-> o_spi_cs == ~(8'd1 << spi_chip) && o_spi_miso_sel == spi_chip)
      else flag_mismatch("spi chip select", {24'd0, ~(8'd1 << spi_chip)}, {24'd0, o_spi_cs});

   a_spi_extra : assert property (@(posedge clk50) disable iff (pllreset2)
      o_spi_tx_dv |-> spi_dv_total - spi_base < spi_len)
      else abort_run("more SPI bytes were sent than the command asked for");

   a_spi_byte : assert property (@(posedge clk50) disable iff (pllreset2)
      o_spi_tx_dv && spi_dv_total - spi_base < spi_len |->
         o_spi_tx == spi_bytes[spi_dv_total - spi_base])
      else flag_mismatch("spi tx byte", spi_bytes[$sampled(spi_dv_total) - spi_base], o_spi_tx);

   initial begin
      pllreset2  <= 1'b1;
      i_rx_valid <= 1'b0;
      i_rx_data  <= 8'd0;
      i_acqstate <= 8'd0;
      i_boardin  <= 8'ha5;
      repeat (16) @(posedge clk50);
      pllreset2 <= 1'b0;
      @(posedge clk50);
      check_field("reset rx_ready", 1, o_rx_ready);
      check_field("reset tx_valid", 0, o_tx_valid);
      check_field("reset spi_tx_dv", 0, o_spi_tx_dv);
      check_field("reset spi_cs", 8'hff, o_spi_cs);
      check_field("reset trig_cfg clear", 1, o_trig_cfg == '0);
      check_field("reset boardout", 0, o_boardout);

      run_cmd("read version", `FW_VERSION, cmd8(`OP_READ, `RD_VERSION, '0, '0, '0, '0, '0, '0));
      run_cmd("read boardin", 32'h0000_00a5, cmd8(`OP_READ, `RD_BOARDIN, '0, '0, '0, '0, '0, '0));
      run_cmd("read unused", 32'd0, cmd8(`OP_READ, 8'd5, '0, '0, '0, '0, '0, '0));
      run_cmd("rolling old", 32'd0, cmd8(`OP_READ, `RD_ROLLING, 8'd1, '0, '0, '0, '0, '0));
      check_field("rolling set", 1, o_trig_cfg.rolling);
      run_cmd("rolling old", 32'd1, cmd8(`OP_READ, `RD_ROLLING, 8'd0, '0, '0, '0, '0, '0));
      check_field("rolling clear", 0, o_trig_cfg.rolling);

      run_trig(8'd140, 8'd5, 8'h02, 8'h40, 8'd20, 8'd1, 8'd3);
      run_trig(8'd100, 8'd40, 8'h03, 8'hff, 8'd7, 8'd0, 8'd200);  // runt rejection off
      run_cmd("downsample echo", 32'd9, cmd8(`OP_DOWNSAMPLE, 8'h33, 8'h01, 8'h07, '0, '0, '0, '0));
      check_field("downsample", 5'h13, o_trig_cfg.downsample);  // b1 bits 4:0
      check_field("high-res", 1, o_trig_cfg.high_res);
      check_field("merging", 8'h07, o_trig_cfg.merging);

      run_arm(8'd0, 8'h02, 8'h34, 8'h12);
      run_arm(8'd3, 8'h05, 8'hcd, 8'hab);

      run_boardout(3'd3, 1'b1);
      run_boardout(3'd0, 1'b1);
      run_boardout(3'd3, 1'b0);

      run_spi(3'd2, 2, 8'h11, 8'h22, 8'h33, 8'h44);
      run_spi(3'd5, 3, 8'ha0, 8'hb1, 8'hc2, 8'hd3);
      run_spi(3'd7, 4, 8'h01, 8'h80, 8'h7f, 8'hfe);

      send_cmd(cmd8(`OP_HANG, '0, '0, '0, '0, '0, '0, '0));
      @(posedge clk50);
      while (!o_rx_ready) @(posedge clk50);  // held until the watchdog aborts
      run_cmd("watchdog count", 32'd1, cmd8(`OP_READ, `RD_WATCHDOG, '0, '0, '0, '0, '0, '0));

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+hw
hw/cmd_pkg.sv
hw/cmd_receiver.sv
hw/resp_sender.sv
hw/spi_sequencer.sv
hw/cmd_dispatcher.sv
hw/command_processor_top.sv
dv/tb_command_processor.sv

// ==== Bender.yml ====
package:
  name: command_processor

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cmd_pkg.sv
      - hw/cmd_receiver.sv
      - hw/resp_sender.sv
      - hw/spi_sequencer.sv
      - hw/cmd_dispatcher.sv
      - hw/command_processor_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/tb_command_processor.sv
